// File: rtl/mcoi_pkg.sv
/*
 * shared definitions of the GEFE motor control application
 * link widths, interlock key and readback constants
 * motor control and status structs, the motor word union
 * states of the slow-control lane framer
 */
package mcoi_pkg;

   // --------------------
   // sizes
   // --------------------
   localparam int N_MOTORS = 16;
   localparam int MOTOR_IDX_W = $clog2(N_MOTORS);
   localparam int SC_WORD_W = 32;
   localparam int SC_CNT_W = $clog2(SC_WORD_W);
   // depth of the status synchronizer
   localparam int SYNC_STAGES = 3;

   // --------------------
   // link constants
   // --------------------
   // the controller closes the interlock by sending this word on lane 1
   localparam logic [31:0] GEFE_INTERLOCK = 32'h1f2e_3d4c;
   localparam logic [31:0] BUILD_NUMBER = 32'h0000_0117;
   localparam logic [3:0] PCB_REV = 4'h3;
   // filler for every page that has no meaning
   localparam logic [31:0] DEAD_WORD = 32'hdead_beef;

   // page codes are decoded on the low byte of the lane 0 word
   localparam logic [7:0] PAGE_LOOPBACK = 8'd0;
   localparam logic [7:0] PAGE_BUILD = 8'd1;
   localparam logic [7:0] PAGE_PCBREV = 8'd2;
   // page base+k returns the status of motor k
   localparam logic [7:0] PAGE_STATUS_BASE = 8'd16;

   // control bits of one motor, all ones deactivates the driver
   typedef struct packed {
      logic boost;
      logic dir;
      logic deactivate;
      logic stepout;
   } motor_ctrl_t;

   // status bits of one motor as returned to the controller
   typedef struct packed {
      logic       pfail;
      logic [1:0] sw;
      logic       overheat;
   } motor_stat_t;

   // the link carries the word raw, the pins take it per motor
   typedef union packed {
      logic [4*N_MOTORS-1:0]          raw;
      motor_ctrl_t [N_MOTORS-1:0]     motor;
   } motor_word_u;

   typedef enum logic [1:0] {
      IDLE,
      DATA,
      GAP
   } sc_state_t;

endpackage

// File: rtl/sc_frame_fsm.sv
/*
 * sc_bit_if, the handshake between lane framer, bit counter and shifters
 * sc_frame_fsm, frames one direction of a slow-control lane
 */
`timescale 1ns/1ns

interface sc_bit_if;
   logic count_clr;
   logic count_en;
   logic last;
   logic rx_shift;
   logic rx_done;
   logic tx_load;
   logic tx_shift;

   modport fsm (
      output count_clr, count_en, rx_shift, rx_done, tx_load, tx_shift,
      input  last
   );
   modport counter (
      input  count_clr, count_en,
      output last
   );
   modport datapath (
      input rx_shift, rx_done, tx_load, tx_shift
   );
endinterface

module sc_frame_fsm #(
   parameter bit tx_dir = 1'b0
) (
   input  logic  gbt_rx_clkrs,
   input  logic  rst_n_i,
   input  logic  rx_clken_i,
   input  logic  line_i,
   sc_bit_if.fsm bit_x
);

   mcoi_pkg::sc_state_t state_q;
   mcoi_pkg::sc_state_t state_d;
   logic start;
   logic in_data;

   // the transmitter opens a frame as soon as it is idle, the receiver
   // waits for the start bit on the line
   assign start = (state_q == mcoi_pkg::IDLE) && (tx_dir || line_i);
   assign in_data = (state_q == mcoi_pkg::DATA);

   always_comb begin
      state_d = state_q;
      case (state_q)
         mcoi_pkg::IDLE: begin
            if (start)
               state_d = mcoi_pkg::DATA;
         end
         mcoi_pkg::DATA: begin
            // bit 31 closes the data part of the frame
            if (bit_x.last)
               state_d = mcoi_pkg::GAP;
         end
         mcoi_pkg::GAP:
            state_d = mcoi_pkg::IDLE;
         default:
            state_d = mcoi_pkg::IDLE;
      endcase
   end

   // the state only moves on cycles that carry a bit
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i)
         state_q <= mcoi_pkg::IDLE;
      else if (rx_clken_i)
         state_q <= state_d;
   end

   // the counter applies the clock enable itself
   assign bit_x.count_clr = start;
   assign bit_x.count_en = in_data;

   // shift strobes are only raised in the direction this framer serves
   assign bit_x.rx_shift = !tx_dir && in_data && rx_clken_i;
   assign bit_x.rx_done = !tx_dir && in_data && rx_clken_i && bit_x.last;
   assign bit_x.tx_load = tx_dir && start && rx_clken_i;
   assign bit_x.tx_shift = tx_dir && in_data && rx_clken_i;

endmodule

// File: rtl/sc_bit_counter.sv
/*
 * counter of the data bits of one slow-control frame
 */
`timescale 1ns/1ns

module sc_bit_counter (
   input  logic      gbt_rx_clkrs,
   input  logic      rst_n_i,
   input  logic      rx_clken_i,
   sc_bit_if.counter bit_x
);

   logic [mcoi_pkg::SC_CNT_W-1:0] count_q;

   // cleared at the start bit, advanced on each enabled data bit
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (rx_clken_i) begin
         if (bit_x.count_clr)
            count_q <= '0;
         else if (bit_x.count_en)
            count_q <= count_q + 1'b1;
      end
   end

   // bit 31 is the one where every count bit is set
   assign bit_x.last = &count_q;

endmodule

// File: rtl/serial_register.sv
/*
 * one slow-control lane of the link
 * receive framer, counter and shift register with word and newdata outputs
 * transmit framer, counter and shift register sending back-to-back frames
 */
`timescale 1ns/1ns

module serial_register (
   input  logic                           gbt_rx_clkrs,
   input  logic                           rst_n_i,
   input  logic                           rx_clken_i,
   input  logic                           rx_i,
   output logic                           tx_o,
   input  logic [mcoi_pkg::SC_WORD_W-1:0] tx_word_i,
   output logic [mcoi_pkg::SC_WORD_W-1:0] word_o,
   output logic                           newdata_o
);

   localparam int W = mcoi_pkg::SC_WORD_W;

   logic [W-1:0] rx_sh_q;
   logic [W-1:0] tx_sh_q;

   sc_bit_if rx_x ();
   sc_bit_if tx_x ();

   // --------------------
   // receive direction
   // --------------------
   sc_frame_fsm #(.tx_dir(1'b0)) i_rx_fsm (
      .gbt_rx_clkrs, .rst_n_i, .rx_clken_i,
      .line_i(rx_i),
      .bit_x(rx_x.fsm)
   );

   sc_bit_counter i_rx_cnt (.gbt_rx_clkrs, .rst_n_i, .rx_clken_i, .bit_x(rx_x.counter));

   // bits arrive MSB first
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rx_x.rx_shift)
         rx_sh_q <= {rx_sh_q[W-2:0], rx_i};
   end

   // the word is published together with its last bit, newdata is one cycle wide
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i) begin
         word_o <= '0;
         newdata_o <= 1'b0;
      end else begin
         newdata_o <= rx_x.rx_done;
         if (rx_x.rx_done)
            word_o <= {rx_sh_q[W-2:0], rx_i};
      end
   end

   // --------------------
   // transmit direction
   // --------------------
   // this framer has no line to watch
   sc_frame_fsm #(.tx_dir(1'b1)) i_tx_fsm (
      .gbt_rx_clkrs, .rst_n_i, .rx_clken_i,
      .line_i(1'b0),
      .bit_x(tx_x.fsm)
   );

   sc_bit_counter i_tx_cnt (.gbt_rx_clkrs, .rst_n_i, .rx_clken_i, .bit_x(tx_x.counter));

   // the outgoing word is sampled at every start bit
   always_ff @(posedge gbt_rx_clkrs) begin
      if (tx_x.tx_load)
         tx_sh_q <= tx_word_i;
      else if (tx_x.tx_shift)
         tx_sh_q <= {tx_sh_q[W-2:0], 1'b0};
   end

   // start bit is 1, then the data, then a 0 on the gap bit
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i)
         tx_o <= 1'b0;
      else if (rx_clken_i)
         tx_o <= tx_x.tx_load ? 1'b1 : (tx_x.tx_shift ? tx_sh_q[W-1] : 1'b0);
   end

   // a frame never holds more than 32 data bits in either direction
   a_rx_frame_len : assert property (@(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      rx_x.rx_shift && rx_x.last |=> i_rx_fsm.state_q == mcoi_pkg::GAP);
   a_tx_frame_len : assert property (@(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      tx_x.tx_shift && tx_x.last |=> i_tx_fsm.state_q == mcoi_pkg::GAP);

endmodule

// File: rtl/motor_interlock.sv
/*
 * interlock gate of the motor control word
 * controls pass only while lane 1 carries the interlock key
 */
`timescale 1ns/1ns

module motor_interlock (
   input  logic                  gbt_rx_clkrs,
   input  logic                  rst_n_i,
   input  mcoi_pkg::motor_word_u motor_data_i,
   input  logic [31:0]           feedback_i,
   output mcoi_pkg::motor_word_u ctrl_o
);

   logic closed;

   // the loop is closed only when the controller returns the key
   assign closed = (feedback_i == mcoi_pkg::GEFE_INTERLOCK);

   // all ones sets deactivate on every motor, so drivers stay off
   // until the link is up and the key is seen
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i)
         ctrl_o <= '1;
      else if (closed)
         ctrl_o.raw <= motor_data_i.raw;
      else
         ctrl_o <= '1;
   end

   // an open interlock parks every driver on the next cycle
   a_open_parks : assert property (@(posedge gbt_rx_clkrs) disable iff (!rst_n_i)
      !closed |=> ctrl_o.raw == '1);

endmodule

// File: rtl/status_sync.sv
/*
 * motor status capture
 * inverts the active-low pins and synchronizes them over three flop stages
 */
`timescale 1ns/1ns

module status_sync (
   input  logic                                            gbt_rx_clkrs,
   input  logic                                            rst_n_i,
   input  logic [mcoi_pkg::N_MOTORS-1:0]                   pfail_n_i,
   input  logic [mcoi_pkg::N_MOTORS-1:0]                   sw_a_n_i,
   input  logic [mcoi_pkg::N_MOTORS-1:0]                   sw_b_n_i,
   output mcoi_pkg::motor_stat_t [mcoi_pkg::N_MOTORS-1:0]  status_o
);

   mcoi_pkg::motor_stat_t [mcoi_pkg::N_MOTORS-1:0] stat_in;
   mcoi_pkg::motor_stat_t [mcoi_pkg::N_MOTORS-1:0] stage_q [mcoi_pkg::SYNC_STAGES];

   // pins are active low, switch a goes to sw bit 0
   always_comb begin
      for (int k = 0; k < mcoi_pkg::N_MOTORS; k++) begin
         stat_in[k].pfail = !pfail_n_i[k];
         stat_in[k].sw = {!sw_b_n_i[k], !sw_a_n_i[k]};
         // no overheat sensing on this board
         stat_in[k].overheat = 1'b0;
      end
   end

   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i) begin
         for (int s = 0; s < mcoi_pkg::SYNC_STAGES; s++)
            stage_q[s] <= '0;
      end else begin
         stage_q[0] <= stat_in;
         for (int s = 1; s < mcoi_pkg::SYNC_STAGES; s++)
            stage_q[s] <= stage_q[s-1];
      end
   end

   assign status_o = stage_q[mcoi_pkg::SYNC_STAGES-1];

endmodule

// File: rtl/readback_mux.sv
/*
 * lane 0 readback
 * loopback register and the page-selected reply word
 */
`timescale 1ns/1ns

module readback_mux (
   input  logic                                           gbt_rx_clkrs,
   input  logic                                           rst_n_i,
   input  logic                                           rx_clken_i,
   input  logic [31:0]                                    page_i,
   input  logic                                           page_new_i,
   input  mcoi_pkg::motor_stat_t [mcoi_pkg::N_MOTORS-1:0] status_i,
   output logic [31:0]                                    word_o
);

   logic [31:0] loopback_q;
   logic [7:0] stat_idx;

   // pages below the status base wrap to large values and fall outside
   assign stat_idx = page_i[7:0] - mcoi_pkg::PAGE_STATUS_BASE;

   // the controller sees bit 31 of its own page word come back
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i)
         loopback_q <= 32'd1;
      else if (page_new_i)
         loopback_q <= {page_i[31], 30'b0, 1'b1};
   end

   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i) begin
         word_o <= '0;
      end else if (rx_clken_i) begin
         word_o <= '0;
         case (page_i[7:0])
            mcoi_pkg::PAGE_LOOPBACK:
               word_o <= loopback_q;
            mcoi_pkg::PAGE_BUILD:
               word_o <= mcoi_pkg::BUILD_NUMBER;
            mcoi_pkg::PAGE_PCBREV:
               word_o[$bits(mcoi_pkg::PCB_REV)-1:0] <= mcoi_pkg::PCB_REV;
            default: begin
               // status of motor k, zero extended
               if (stat_idx < 8'(mcoi_pkg::N_MOTORS))
                  word_o[$bits(mcoi_pkg::motor_stat_t)-1:0] <=
                     status_i[stat_idx[mcoi_pkg::MOTOR_IDX_W-1:0]];
               else
                  word_o <= mcoi_pkg::DEAD_WORD;
            end
         endcase
      end
   end

endmodule

// File: rtl/mcoi_gefe_app.sv
/*
 * GEFE application of the stepper motor link, sixteen motors on one fiber
 * lane 0 page readback, lane 1 interlock echo
 * interlock gate to the driver pins, synchronized statuses back to the link
 */
`timescale 1ns/1ns

module mcoi_gefe_app (
   input  logic                          gbt_rx_clkrs,
   input  logic                          rst_n_i,
   input  logic                          rx_clken_i,
   input  logic [63:0]                   motor_data_i,
   input  logic [1:0]                    sc_rx_i,
   output logic [1:0]                    sc_tx_o,
   output logic [mcoi_pkg::N_MOTORS-1:0] pl_boost_o,
   output logic [mcoi_pkg::N_MOTORS-1:0] pl_dir_o,
   output logic [mcoi_pkg::N_MOTORS-1:0] pl_en_o,
   output logic [mcoi_pkg::N_MOTORS-1:0] pl_clk_o,
   input  logic [mcoi_pkg::N_MOTORS-1:0] pl_pfail_n_i,
   input  logic [mcoi_pkg::N_MOTORS-1:0] pl_sw_outa_n_i,
   input  logic [mcoi_pkg::N_MOTORS-1:0] pl_sw_outb_n_i,
   output logic [63:0]                   status_data_o
);

   logic [31:0] page_w;
   logic        page_new;
   logic [31:0] fb_word;
   logic        fb_new;
   logic [31:0] fb_echo_q;
   logic [31:0] mux_word;

   mcoi_pkg::motor_word_u motor_in;
   mcoi_pkg::motor_word_u motor_ctrl;
   mcoi_pkg::motor_stat_t [mcoi_pkg::N_MOTORS-1:0] motor_stat;

   // --------------------
   // slow control lanes
   // --------------------
   // lane 0 receives the page selector and answers with the readback word
   serial_register i_lane_page (
      .gbt_rx_clkrs, .rst_n_i, .rx_clken_i,
      .rx_i(sc_rx_i[0]),
      .tx_o(sc_tx_o[0]),
      .tx_word_i(mux_word),
      .word_o(page_w),
      .newdata_o(page_new)
   );

   // lane 1 receives the interlock word and returns it to the controller
   serial_register i_lane_feedback (
      .gbt_rx_clkrs, .rst_n_i, .rx_clken_i,
      .rx_i(sc_rx_i[1]),
      .tx_o(sc_tx_o[1]),
      .tx_word_i(fb_echo_q),
      .word_o(fb_word),
      .newdata_o(fb_new)
   );

   // echo register, trails the received feedback word by one cycle
   always_ff @(posedge gbt_rx_clkrs) begin
      if (!rst_n_i)
         fb_echo_q <= '0;
      else if (fb_new)
         fb_echo_q <= fb_word;
   end

   // --------------------
   // motor controls
   // --------------------
   assign motor_in.raw = motor_data_i;

   motor_interlock i_interlock (
      .gbt_rx_clkrs, .rst_n_i,
      .motor_data_i(motor_in),
      .feedback_i(fb_word),
      .ctrl_o(motor_ctrl)
   );

   // each field of the gated word goes to its own pin
   for (genvar k = 0; k < mcoi_pkg::N_MOTORS; k++) begin : g_pins
      assign pl_boost_o[k] = motor_ctrl.motor[k].boost;
      assign pl_dir_o[k] = motor_ctrl.motor[k].dir;
      assign pl_en_o[k] = motor_ctrl.motor[k].deactivate;
      assign pl_clk_o[k] = motor_ctrl.motor[k].stepout;
   end

   // --------------------
   // statuses and readback
   // --------------------
   status_sync i_status_sync (
      .gbt_rx_clkrs, .rst_n_i,
      .pfail_n_i(pl_pfail_n_i),
      .sw_a_n_i(pl_sw_outa_n_i),
      .sw_b_n_i(pl_sw_outb_n_i),
      .status_o(motor_stat)
   );

   // statuses go back on the link in the motor word slot
   assign status_data_o = motor_stat;

   readback_mux i_readback_mux (
      .gbt_rx_clkrs, .rst_n_i, .rx_clken_i,
      .page_i(page_w),
      .page_new_i(page_new),
      .status_i(motor_stat),
      .word_o(mux_word)
   );

endmodule

// File: dv/tb_clkgen.sv
/*
 * testbench clock and reset source
 * 10 ns clock, synchronous active-low reset held for 5 cycles
 */
`timescale 1ns/1ns

module tb_clkgen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // reset is released on a rising edge, like any other stimulus
   initial begin
      rst_n_o = 1'b0;
      repeat (5) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// File: dv/tb_checker.sv
/*
 * testbench checker of the GEFE application
 * reference models of the interlock gate, status pipeline and readback pages
 * deserializers of both lanes in both directions, per-test reporting
 */
`timescale 1ns/1ns

module tb_checker (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        rx_clken_i,
   input  logic [63:0] motor_data_i,
   input  logic [1:0]  sc_rx_i,
   input  logic [1:0]  sc_tx_i,
   input  logic [15:0] boost_i,
   input  logic [15:0] dir_i,
   input  logic [15:0] en_i,
   input  logic [15:0] stepclk_i,
   input  logic [15:0] pfail_n_i,
   input  logic [15:0] sw_a_n_i,
   input  logic [15:0] sw_b_n_i,
   input  logic [63:0] status_data_i,
   output int          rep0_o,
   output int          rep1_o,
   output int          err_cnt_o
);

   logic [63:0] exp_ctrl;
   logic [63:0] stat_pipe [3];
   logic [31:0] fb_ref;
   logic [31:0] loop_ref;
   logic [31:0] page_ref;
   // receive side models of the DUT framers
   logic [1:0]  rx_st [2];
   int          rx_cnt [2];
   logic [31:0] rx_sh [2];
   // reply deserializers
   bit          tx_busy [2];
   int          tx_cnt [2];
   logic [31:0] tx_sh [2];
   time         tx_start [2];
   logic        en_d;
   int          settle [2];
   bit          armed [2];
   time         arm_t [2];
   int          replies [2];
   int          errs;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   string       test_name;

   assign rep0_o = replies[0];
   assign rep1_o = replies[1];
   assign err_cnt_o = errs + tests_failed;

   // --------------------
   // reference functions
   // --------------------
   // controls pass only while the feedback word is the key
   function automatic logic [63:0] gate_ctrl(input logic [63:0] md, input logic [31:0] fb);
      return (fb == mcoi_pkg::GEFE_INTERLOCK) ? md : '1;
   endfunction

   // per motor nibble is pfail, sw b, sw a, overheat, all active high
   function automatic logic [63:0] status_word(input logic [15:0] pf, input logic [15:0] a,
                                               input logic [15:0] b);
      logic [63:0] w;
      for (int k = 0; k < 16; k++)
         w[4*k +: 4] = {~pf[k], ~b[k], ~a[k], 1'b0};
      return w;
   endfunction

   function automatic logic [31:0] page_reply(input logic [31:0] page, input logic [31:0] loop,
                                              input logic [63:0] stat);
      int k;
      k = int'(page[7:0]) - 16;
      if (page[7:0] == 8'd0)
         return loop;
      if (page[7:0] == 8'd1)
         return mcoi_pkg::BUILD_NUMBER;
      if (page[7:0] == 8'd2)
         return {28'b0, mcoi_pkg::PCB_REV};
      if (k >= 0 && k < mcoi_pkg::N_MOTORS)
         return {28'b0, stat[4*k +: 4]};
      return mcoi_pkg::DEAD_WORD;
   endfunction

   task automatic flag_error(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      errs++;
      test_errs++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, test_errs);
      end
   endtask

   task automatic report();
      $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errs);
   endtask

   // only a frame whose start bit was loaded after the reply settled is compared
   task automatic check_reply(input int l, input logic [31:0] got_w);
      logic [31:0] exp_w;
      if (armed[l] && tx_start[l] > arm_t[l]) begin
         if (l == 0)
            exp_w = page_reply(page_ref, loop_ref, status_word(pfail_n_i, sw_a_n_i, sw_b_n_i));
         else
            exp_w = fb_ref;
         if (got_w !== exp_w)
            flag_error($sformatf("lane %0d reply %h, expected %h", l, got_w, exp_w));
         armed[l] = 1'b0;
         replies[l]++;
      end
   endtask

   // --------------------
   // comparing process
   // --------------------
   always @(posedge clk_i) begin
      logic [63:0] act;
      if (!rst_n_i) begin
         exp_ctrl = '1;
         for (int s = 0; s < 3; s++)
            stat_pipe[s] = '0;
         fb_ref = '0;
         loop_ref = 32'd1;
         page_ref = '0;
         en_d = 1'b0;
         for (int l = 0; l < 2; l++) begin
            rx_st[l] = 2'd0;
            tx_busy[l] = 1'b0;
            settle[l] = 0;
            armed[l] = 1'b0;
         end
      end else begin
         for (int k = 0; k < 16; k++)
            act[4*k +: 4] = {boost_i[k], dir_i[k], en_i[k], stepclk_i[k]};
         if (act !== exp_ctrl)
            flag_error($sformatf("motor pins %h, expected %h", act, exp_ctrl));
         if (status_data_i !== stat_pipe[2])
            flag_error($sformatf("status word %h, expected %h", status_data_i, stat_pipe[2]));
         stat_pipe[2] = stat_pipe[1];
         stat_pipe[1] = stat_pipe[0];
         stat_pipe[0] = status_word(pfail_n_i, sw_a_n_i, sw_b_n_i);
         // the gate sees the feedback word from before this edge
         exp_ctrl = gate_ctrl(motor_data_i, fb_ref);

         // reply bits are valid on the cycle after an enabled cycle
         for (int l = 0; l < 2; l++) begin
            if (en_d && !tx_busy[l] && sc_tx_i[l]) begin
               tx_busy[l] = 1'b1;
               tx_cnt[l] = 0;
               tx_start[l] = $time - 10;
            end else if (en_d && tx_busy[l]) begin
               tx_sh[l] = {tx_sh[l][30:0], sc_tx_i[l]};
               tx_cnt[l]++;
               if (tx_cnt[l] == 32) begin
                  tx_busy[l] = 1'b0;
                  check_reply(l, tx_sh[l]);
               end
            end
         end
         en_d = rx_clken_i;

         // two enabled cycles let the received word reach the readback mux
         if (rx_clken_i) begin
            for (int l = 0; l < 2; l++) begin
               if (settle[l] > 0) begin
                  settle[l]--;
                  if (settle[l] == 0) begin
                     armed[l] = 1'b1;
                     arm_t[l] = $time;
                  end
               end
            end
         end

         // receive framing, same as the DUT lanes
         if (rx_clken_i) begin
            for (int l = 0; l < 2; l++) begin
               case (rx_st[l])
                  2'd0: begin
                     if (sc_rx_i[l]) begin
                        rx_st[l] = 2'd1;
                        rx_cnt[l] = 0;
                     end
                  end
                  2'd1: begin
                     rx_sh[l] = {rx_sh[l][30:0], sc_rx_i[l]};
                     rx_cnt[l]++;
                     if (rx_cnt[l] == 32) begin
                        rx_st[l] = 2'd2;
                        settle[l] = 2;
                        armed[l] = 1'b0;
                        if (l == 1) begin
                           fb_ref = rx_sh[l];
                        end else begin
                           page_ref = rx_sh[l];
                           loop_ref = {rx_sh[l][31], 30'b0, 1'b1};
                        end
                     end
                  end
                  default:
                     rx_st[l] = 2'd0;
               endcase
            end
         end
      end
   end

endmodule

// File: dv/tb_mcoi_gefe_app.sv
/*
 * testbench top of the GEFE application
 * stimulus, Galois LFSR, serial lane senders and the watchdog
 */
`timescale 1ns/1ns

module tb_mcoi_gefe_app;

   localparam int N_TESTS = 5;
   // with the enable high on half the cycles a bit takes two cycles
   localparam int BIT_CYCLES = 2;
   localparam longint TIME_LIMIT = longint'(N_TESTS) * 2000 * BIT_CYCLES * 10;

   logic        clk;
   logic        rst_n;
   logic        rx_clken;
   logic [63:0] motor_data;
   logic [1:0]  sc_rx;
   logic [1:0]  sc_tx;
   logic [15:0] boost;
   logic [15:0] dir;
   logic [15:0] en;
   logic [15:0] stepclk;
   logic [15:0] pfail_n;
   logic [15:0] sw_a_n;
   logic [15:0] sw_b_n;
   logic [63:0] status_data;
   logic        drive_motor;
   logic [31:0] lfsr_q;
   bit          lane0_bits [$];
   bit          lane1_bits [$];
   int          rep0;
   int          rep1;
   int          err_cnt;

   tb_clkgen u_clk (.clk_o(clk), .rst_n_o(rst_n));

   mcoi_gefe_app UUT (
      .gbt_rx_clkrs(clk), .rst_n_i(rst_n), .rx_clken_i(rx_clken),
      .motor_data_i(motor_data), .sc_rx_i(sc_rx), .sc_tx_o(sc_tx),
      .pl_boost_o(boost), .pl_dir_o(dir), .pl_en_o(en), .pl_clk_o(stepclk),
      .pl_pfail_n_i(pfail_n), .pl_sw_outa_n_i(sw_a_n), .pl_sw_outb_n_i(sw_b_n),
      .status_data_o(status_data)
   );

   tb_checker u_chk (
      .clk_i(clk), .rst_n_i(rst_n), .rx_clken_i(rx_clken), .motor_data_i(motor_data),
      .sc_rx_i(sc_rx), .sc_tx_i(sc_tx), .boost_i(boost), .dir_i(dir), .en_i(en),
      .stepclk_i(stepclk), .pfail_n_i(pfail_n), .sw_a_n_i(sw_a_n), .sw_b_n_i(sw_b_n),
      .status_data_i(status_data), .rep0_o(rep0), .rep1_o(rep1), .err_cnt_o(err_cnt)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[62:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return r;
   endfunction

   // start bit, 32 data bits MSB first, one gap bit, then wait for the reply
   task automatic transact(input int lane, input logic [31:0] w);
      bit fr [$];
      int n0;
      n0 = (lane == 0) ? rep0 : rep1;
      fr.push_back(1'b1);
      for (int i = 31; i >= 0; i--)
         fr.push_back(w[i]);
      fr.push_back(1'b0);
      if (lane == 0)
         lane0_bits = fr;
      else
         lane1_bits = fr;
      wait ((lane == 0) ? (rep0 > n0) : (rep1 > n0));
   endtask

   initial begin
      lfsr_q = 32'hb14f;
      rx_clken = 1'b0;
      motor_data = '0;
      sc_rx = '0;
      pfail_n = '1;
      sw_a_n = '1;
      sw_b_n = '1;
      drive_motor = 1'b0;
   end

   // the enable, the lane bits and the motor word all move on the rising edge
   always @(posedge clk) begin
      logic [63:0] r;
      r = rand_bits(1);
      rx_clken <= r[0];
      if (r[0]) begin
         sc_rx[0] <= (lane0_bits.size() > 0) ? lane0_bits.pop_front() : 1'b0;
         sc_rx[1] <= (lane1_bits.size() > 0) ? lane1_bits.pop_front() : 1'b0;
      end
      if (drive_motor)
         motor_data <= rand_bits(64);
   end

   initial begin
      logic [31:0] w;
      @(posedge rst_n);
      repeat (3) @(posedge clk);
      u_chk.start_test("interlock closed");
      drive_motor <= 1'b1;
      transact(1, mcoi_pkg::GEFE_INTERLOCK);
      repeat (100) @(posedge clk);
      u_chk.finish_test();

      u_chk.start_test("interlock open");
      w = 32'(rand_bits(32));
      if (w == mcoi_pkg::GEFE_INTERLOCK)
         w = ~w;
      transact(1, w);
      repeat (100) @(posedge clk);
      u_chk.finish_test();

      u_chk.start_test("lane 1 echo");
      repeat (4)
         transact(1, 32'(rand_bits(32)));
      u_chk.finish_test();

      u_chk.start_test("readback pages");
      transact(0, {1'b1, 23'(rand_bits(23)), 8'd0});
      transact(0, {1'b0, 23'(rand_bits(23)), 8'd0});
      transact(0, 32'd1);
      transact(0, 32'd2);
      transact(0, 32'd9);
      u_chk.finish_test();

      u_chk.start_test("status readback");
      @(posedge clk);
      pfail_n <= 16'(rand_bits(16));
      sw_a_n <= 16'(rand_bits(16));
      sw_b_n <= 16'(rand_bits(16));
      repeat (10) @(posedge clk);
      for (int k = 16; k < 32; k++)
         transact(0, 32'(k));
      u_chk.finish_test();

      u_chk.report();
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog over the whole run
   initial begin
      #(TIME_LIMIT);
      $display("timeout: a reply frame did not come back in time");
      $display("Verification failed");
      $finish;
   end

endmodule

// File: vlog.f
rtl/mcoi_pkg.sv
rtl/sc_frame_fsm.sv
rtl/sc_bit_counter.sv
rtl/serial_register.sv
rtl/motor_interlock.sv
rtl/status_sync.sv
rtl/readback_mux.sv
rtl/mcoi_gefe_app.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_mcoi_gefe_app.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mcoi_gefe_app
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
